/* compile.f */
verilog/ndn_pkg.sv
verilog/link_pkg.sv
verilog/ndn_pkt_if.sv
verilog/ndn_link_tx.sv
verilog/ndn_link_rx.sv
verilog/link_cfg.sv
verilog/ndn_link_top.sv
test/tb_ndn_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the NDN link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_tb_ndn_link

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_ndn_link \
    --Mdir obj_dir \
    -o sim_tb_ndn_link
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* test/tb_ndn_link.sv */
// Self-checking testbench for the NDN serial link with loopback and miso frames
module tb_ndn_link;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PREFIX_BITS = ndn_pkg::PREFIX_BITS_DEF;
    localparam int DATA_BITS   = ndn_pkg::DATA_BITS_DEF;
    localparam int CNT_W       = 16;
    localparam int VEC_W       = (PREFIX_BITS > DATA_BITS) ? PREFIX_BITS : DATA_BITS;
    // Longest frame, start bit plus every field
    localparam int DATA_FRAME  = 1 + ndn_pkg::META_BITS + PREFIX_BITS + DATA_BITS;
    // 4 interest, 20 mixed, 2 in the drop test, 2 on miso
    localparam int NUM_FRAMES  = 28;
    // Extra frame lengths cover the quiet waits of the drop test
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (DATA_FRAME + 4) + 4 * DATA_FRAME + 500;

    typedef struct packed {
        ndn_pkg::ndn_meta_t     meta;
        logic [PREFIX_BITS-1:0] prefix;
        logic [DATA_BITS-1:0]   data;
    } pkt_t;

    logic                   clk;
    logic                   rst;
    logic                   tx_valid;
    ndn_pkg::ndn_meta_t     tx_meta;
    logic [PREFIX_BITS-1:0] tx_prefix;
    logic [DATA_BITS-1:0]   tx_data;
    logic                   tx_busy;
    logic                   mosi;
    logic                   miso;
    logic                   rx_valid;
    ndn_pkg::ndn_meta_t     rx_meta;
    logic [PREFIX_BITS-1:0] rx_prefix;
    logic [DATA_BITS-1:0]   rx_data;
    logic                   cfg_we;
    link_pkg::cfg_addr_e    cfg_addr;
    logic [CNT_W-1:0]       cfg_wdata;
    logic [CNT_W-1:0]       cfg_rdata;

    integer seed;
    int     error_count;
    int     check_total;
    int     cycle_count;
    // Expected counter values, by kind
    int     exp_tx;
    int     exp_int;
    int     exp_data;
    pkt_t   exp_q[$];
    pkt_t   exp_pkt;
    pkt_t   p;

    ndn_link_top #(
        .PREFIX_BITS (PREFIX_BITS),
        .DATA_BITS   (DATA_BITS),
        .CNT_W       (CNT_W)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_meta   (tx_meta),
        .tx_prefix (tx_prefix),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .mosi      (mosi),
        .miso      (miso),
        .rx_valid  (rx_valid),
        .rx_meta   (rx_meta),
        .rx_prefix (rx_prefix),
        .rx_data   (rx_data),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference model, an interest carries no content on the line
    function automatic pkt_t expected_rx(input pkt_t sent);
        pkt_t exp;
        exp = sent;
        if (sent.meta.kind == ndn_pkg::PKT_INTEREST) begin
            exp.data = '0;
        end
        return exp;
    endfunction

    // Wide random vector built from 32-bit draws
    function automatic logic [VEC_W-1:0] rand_vec();
        logic [VEC_W-1:0] v;
        v = '0;
        for (int i = 0; i < VEC_W; i += 32) begin
            v = (v << 32) | VEC_W'($unsigned($random(seed)));
        end
        return v;
    endfunction

    function automatic pkt_t rand_pkt(input logic interest_only);
        pkt_t             r;
        logic [VEC_W-1:0] v;
        r.meta = ndn_pkg::ndn_meta_t'(8'($random(seed)));
        if (interest_only) begin
            r.meta.kind = ndn_pkg::PKT_INTEREST;
        end
        v        = rand_vec();
        r.prefix = v[PREFIX_BITS-1:0];
        v        = rand_vec();
        r.data   = v[DATA_BITS-1:0];
        return r;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
                               input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pkt(input ndn_pkg::ndn_meta_t got_meta,
                             input logic [PREFIX_BITS-1:0] got_prefix,
                             input logic [DATA_BITS-1:0] got_data, input pkt_t exp);
        check_total++;
        if (got_meta !== exp.meta || got_prefix !== exp.prefix || got_data !== exp.data) begin
            error_count++;
            $display("Mismatch at %0t: rx packet meta %h prefix %h data %h", $time,
                     got_meta, got_prefix, got_data);
            $display("  expected meta %h prefix %h data %h", exp.meta, exp.prefix, exp.data);
        end
    endtask

    task automatic write_reg(input link_pkg::cfg_addr_e addr, input logic [CNT_W-1:0] value);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    // Read data is combinational, sampled shortly after the address settles
    task automatic expect_reg(input link_pkg::cfg_addr_e addr, input logic [CNT_W-1:0] exp,
                              input string what);
        @(negedge clk);
        cfg_addr = addr;
        #1;
        check_count(cfg_rdata, exp, what);
    endtask

    // One-cycle tx_valid pulse once the transmitter is free
    task automatic send_pkt(input pkt_t s);
        @(negedge clk);
        while (tx_busy) @(negedge clk);
        tx_valid  = 1'b1;
        tx_meta   = s.meta;
        tx_prefix = s.prefix;
        tx_data   = s.data;
        exp_q.push_back(expected_rx(s));
        exp_tx++;
        if (s.meta.kind == ndn_pkg::PKT_INTEREST) exp_int++;
        else exp_data++;
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    // Frame built bit by bit from the line format, MSB first
    task automatic drive_miso_frame(input pkt_t s);
        logic [7:0] meta_bits;
        meta_bits = s.meta;
        exp_q.push_back(expected_rx(s));
        if (s.meta.kind == ndn_pkg::PKT_INTEREST) exp_int++;
        else exp_data++;
        @(negedge clk);
        miso = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            @(negedge clk);
            miso = meta_bits[i];
        end
        for (int i = PREFIX_BITS - 1; i >= 0; i--) begin
            @(negedge clk);
            miso = s.prefix[i];
        end
        if (s.meta.kind == ndn_pkg::PKT_DATA) begin
            for (int i = DATA_BITS - 1; i >= 0; i--) begin
                @(negedge clk);
                miso = s.data[i];
            end
        end
        @(negedge clk);
        miso = 1'b1;
    endtask

    task automatic wait_rx_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // Received packets compared in order, rx_valid is stable at the falling edge
    always @(negedge clk) begin
        if (!rst && rx_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Error at %0t: a packet arrived when none was expected", $time);
            end else begin
                exp_pkt = exp_q.pop_front();
                check_pkt(rx_meta, rx_prefix, rx_data, exp_pkt);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed        = 32'h9ac2_4545;
        error_count = 0;
        check_total = 0;
        exp_tx      = 0;
        exp_int     = 0;
        exp_data    = 0;
        rst         = 1'b1;
        tx_valid    = 1'b0;
        tx_meta     = '0;
        tx_prefix   = '0;
        tx_data     = '0;
        miso        = 1'b1;
        cfg_we      = 1'b0;
        cfg_addr    = link_pkg::CFG_CTRL;
        cfg_wdata   = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset state
        @(negedge clk);
        check_bit(mosi, 1'b1, "mosi after reset");
        check_bit(tx_busy, 1'b0, "tx_busy after reset");
        check_bit(rx_valid, 1'b0, "rx_valid after reset");
        expect_reg(link_pkg::CFG_CTRL, 1, "CTRL after reset");
        expect_reg(link_pkg::CFG_TX_CNT, 0, "TX_CNT after reset");
        expect_reg(link_pkg::CFG_RX_INT_CNT, 0, "RX_INT_CNT after reset");
        expect_reg(link_pkg::CFG_RX_DATA_CNT, 0, "RX_DATA_CNT after reset");

        // Loopback on, interests only
        write_reg(link_pkg::CFG_CTRL, 3);
        repeat (4) send_pkt(rand_pkt(1'b1));
        wait_rx_drain();

        // Mixed kinds, sent back to back
        repeat (20) send_pkt(rand_pkt(1'b0));
        wait_rx_drain();

        // Pulse while busy is dropped
        p = rand_pkt(1'b0);
        p.meta.kind = ndn_pkg::PKT_DATA;
        send_pkt(p);
        repeat (3) @(negedge clk);
        check_bit(tx_busy, 1'b1, "tx_busy during frame");
        tx_valid  = 1'b1;
        tx_prefix = ~p.prefix;
        @(negedge clk);
        tx_valid = 1'b0;
        wait_rx_drain();
        // Quiet window, a stray frame would reach the compare process
        repeat (DATA_FRAME) @(negedge clk);
        expect_reg(link_pkg::CFG_TX_CNT, CNT_W'(exp_tx), "TX_CNT after dropped pulse");

        // Transmit disabled, line stays idle
        write_reg(link_pkg::CFG_CTRL, 2);
        tx_valid = 1'b1;
        @(negedge clk);
        tx_valid = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_bit(mosi, 1'b1, "mosi while disabled");
        end
        check_bit(tx_busy, 1'b0, "tx_busy while disabled");
        expect_reg(link_pkg::CFG_TX_CNT, CNT_W'(exp_tx), "TX_CNT while disabled");
        write_reg(link_pkg::CFG_CTRL, 3);

        // Counters by kind, then cleared by a write
        expect_reg(link_pkg::CFG_RX_INT_CNT, CNT_W'(exp_int), "RX_INT_CNT");
        expect_reg(link_pkg::CFG_RX_DATA_CNT, CNT_W'(exp_data), "RX_DATA_CNT");
        write_reg(link_pkg::CFG_TX_CNT, 16'h5a5a);
        expect_reg(link_pkg::CFG_TX_CNT, 0, "TX_CNT after clear");
        write_reg(link_pkg::CFG_RX_INT_CNT, 16'h5a5a);
        expect_reg(link_pkg::CFG_RX_INT_CNT, 0, "RX_INT_CNT after clear");
        write_reg(link_pkg::CFG_RX_DATA_CNT, 16'h5a5a);
        expect_reg(link_pkg::CFG_RX_DATA_CNT, 0, "RX_DATA_CNT after clear");
        exp_tx   = 0;
        exp_int  = 0;
        exp_data = 0;

        // Loopback off, frames from the far end on miso
        write_reg(link_pkg::CFG_CTRL, 1);
        p = rand_pkt(1'b0);
        p.meta.kind = ndn_pkg::PKT_DATA;
        drive_miso_frame(p);
        drive_miso_frame(rand_pkt(1'b1));
        wait_rx_drain();
        expect_reg(link_pkg::CFG_RX_INT_CNT, CNT_W'(exp_int), "RX_INT_CNT after miso");
        expect_reg(link_pkg::CFG_RX_DATA_CNT, CNT_W'(exp_data), "RX_DATA_CNT after miso");
        expect_reg(link_pkg::CFG_TX_CNT, 0, "TX_CNT after miso");

        $display("Checks run: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog/link_cfg.sv */
// Link config block with control, frame counters and loopback line select
module link_cfg #(
    parameter int CNT_W = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_we,
    input  link_pkg::cfg_addr_e cfg_addr,
    input  logic [CNT_W-1:0]    cfg_wdata,
    output logic [CNT_W-1:0]    cfg_rdata,
    input  logic                tx_start,
    ndn_pkt_if.mon              rx_mon,
    input  logic                mosi,
    input  logic                miso,
    output logic                tx_enable,
    output logic                rx_line
);

    // Slot 0 counts accepted sends, slot 1 received interests and slot 2 received data
    localparam int NUM_CNT = 3;

    logic                loopback;
    logic [NUM_CNT-1:0]  cnt_inc;
    logic [CNT_W-1:0]    cnt_q [NUM_CNT];

    // CTRL bit 0 enables transmit, bit 1 loops mosi back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_enable <= 1'b1;
            loopback  <= 1'b0;
        end else if (cfg_we && (cfg_addr == link_pkg::CFG_CTRL)) begin
            tx_enable <= cfg_wdata[0];
            loopback  <= cfg_wdata[1];
        end
    end

    // Receive counts split by the kind of the finished packet
    assign cnt_inc[0] = tx_start;
    assign cnt_inc[1] = rx_mon.valid && (rx_mon.meta.kind == ndn_pkg::PKT_INTEREST);
    assign cnt_inc[2] = rx_mon.valid && (rx_mon.meta.kind == ndn_pkg::PKT_DATA);

    for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
        logic cnt_clr;

        // Counter i sits at register address i + 1
        assign cnt_clr = cfg_we && (cfg_addr == link_pkg::cfg_addr_e'(i + 1));

        // Clear beats a same-cycle increment
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt_q[i] <= '0;
            end else if (cnt_clr) begin
                cnt_q[i] <= '0;
            end else if (cnt_inc[i]) begin
                cnt_q[i] <= cnt_q[i] + CNT_W'(1);
            end
        end

        // A counter only moves to a nonzero value on an increment without a clear
        a_clr_wins: assert property (@(posedge clk) disable iff (rst)
            (cnt_q[i] != $past(cnt_q[i])) && (cnt_q[i] != '0)
            |-> $past(cnt_inc[i]) && !$past(cnt_clr));
    end

    // Receiver input from internal loopback or the far end
    assign rx_line = loopback ? mosi : miso;

    // Combinational read decode
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            link_pkg::CFG_CTRL: begin
                cfg_rdata[0] = tx_enable;
                cfg_rdata[1] = loopback;
            end
            link_pkg::CFG_TX_CNT:      cfg_rdata = cnt_q[0];
            link_pkg::CFG_RX_INT_CNT:  cfg_rdata = cnt_q[1];
            link_pkg::CFG_RX_DATA_CNT: cfg_rdata = cnt_q[2];
            default:                   cfg_rdata = '0;
        endcase
    end

endmodule

/* verilog/link_pkg.sv */
// Serial link package with FSM states, config register opcodes and line levels
package link_pkg;

    // Common frame walk, shared by both directions
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_META   = 2'd1,
        ST_PREFIX = 2'd2,
        ST_DATA   = 2'd3
    } link_state_e;

    // Transmit and receive FSMs step through the same fields
    typedef link_state_e tx_state_e;
    typedef link_state_e rx_state_e;

    // Config register map
    typedef enum logic [1:0] {
        CFG_CTRL        = 2'd0,
        CFG_TX_CNT      = 2'd1,
        CFG_RX_INT_CNT  = 2'd2,
        CFG_RX_DATA_CNT = 2'd3
    } cfg_addr_e;

    // Line level between frames, the start bit is its inverse
    localparam logic LINE_IDLE = 1'b1;

endpackage

/* verilog/ndn_link_rx.sv */
// Frame deserializer detecting the start bit, filling the fields and pulsing valid
module ndn_link_rx #(
    parameter int PREFIX_BITS = ndn_pkg::PREFIX_BITS_DEF,
    parameter int DATA_BITS   = ndn_pkg::DATA_BITS_DEF
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rx_line,
    ndn_pkt_if.src pkt
);

    localparam int META_BITS = ndn_pkg::META_BITS;
    // Same counter sizing as the transmitter
    localparam int MAX_PD    = (PREFIX_BITS > DATA_BITS) ? PREFIX_BITS : DATA_BITS;
    localparam int MAX_FIELD = (MAX_PD > META_BITS) ? MAX_PD : META_BITS;
    localparam int BIT_W     = $clog2(MAX_FIELD);

    link_pkg::rx_state_e state;
    logic [BIT_W-1:0]    bit_cnt;
    logic                start_bit;
    logic                field_done;

    assign start_bit  = (state == link_pkg::ST_IDLE) && (rx_line != link_pkg::LINE_IDLE);
    assign field_done = (bit_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= link_pkg::ST_IDLE;
            bit_cnt   <= '0;
            pkt.valid <= 1'b0;
        end else begin
            // Strobe defaults low, set only on the last bit
            pkt.valid <= 1'b0;
            case (state)
                link_pkg::ST_IDLE: begin
                    if (start_bit) begin
                        state   <= link_pkg::ST_META;
                        bit_cnt <= BIT_W'(META_BITS - 1);
                    end
                end
                link_pkg::ST_META: begin
                    if (field_done) begin
                        state   <= link_pkg::ST_PREFIX;
                        bit_cnt <= BIT_W'(PREFIX_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                link_pkg::ST_PREFIX: begin
                    if (field_done) begin
                        // Meta is complete by now, so the kind bit is settled
                        if (pkt.meta.kind == ndn_pkg::PKT_INTEREST) begin
                            pkt.valid <= 1'b1;
                            state     <= link_pkg::ST_IDLE;
                        end else begin
                            state   <= link_pkg::ST_DATA;
                            bit_cnt <= BIT_W'(DATA_BITS - 1);
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: begin
                    if (field_done) begin
                        pkt.valid <= 1'b1;
                        state     <= link_pkg::ST_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Field registers, MSB first so each bit enters at the bottom
    always_ff @(posedge clk) begin
        case (state)
            link_pkg::ST_IDLE: begin
                // Interest packets must report empty content
                if (start_bit) begin
                    pkt.data <= '0;
                end
            end
            link_pkg::ST_META: begin
                pkt.meta <= {pkt.meta[META_BITS-2:0], rx_line};
            end
            link_pkg::ST_PREFIX: begin
                pkt.prefix <= {pkt.prefix[PREFIX_BITS-2:0], rx_line};
            end
            default: begin
                pkt.data <= {pkt.data[DATA_BITS-2:0], rx_line};
            end
        endcase
    end

    // A frame is far longer than one cycle, so valid can never repeat
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        pkt.valid |=> !pkt.valid);

endmodule

/* verilog/ndn_link_top.sv */
// NDN serial link top level tying transmitter, receiver and config block together
module ndn_link_top #(
    parameter int PREFIX_BITS = ndn_pkg::PREFIX_BITS_DEF,
    parameter int DATA_BITS   = ndn_pkg::DATA_BITS_DEF,
    parameter int CNT_W       = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    // Forwarder side, transmit
    input  logic                   tx_valid,
    input  ndn_pkg::ndn_meta_t     tx_meta,
    input  logic [PREFIX_BITS-1:0] tx_prefix,
    input  logic [DATA_BITS-1:0]   tx_data,
    output logic                   tx_busy,
    // Serial line
    output logic                   mosi,
    input  logic                   miso,
    // Forwarder side, receive
    output logic                   rx_valid,
    output ndn_pkg::ndn_meta_t     rx_meta,
    output logic [PREFIX_BITS-1:0] rx_prefix,
    output logic [DATA_BITS-1:0]   rx_data,
    // Register port
    input  logic                   cfg_we,
    input  link_pkg::cfg_addr_e    cfg_addr,
    input  logic [CNT_W-1:0]       cfg_wdata,
    output logic [CNT_W-1:0]       cfg_rdata
);

    logic tx_enable;
    logic tx_start;
    logic rx_line;

    ndn_pkt_if #(.PREFIX_BITS(PREFIX_BITS), .DATA_BITS(DATA_BITS)) tx_pkt ();
    ndn_pkt_if #(.PREFIX_BITS(PREFIX_BITS), .DATA_BITS(DATA_BITS)) rx_pkt ();

    // Outgoing packet straight from the ports
    assign tx_pkt.valid  = tx_valid;
    assign tx_pkt.meta   = tx_meta;
    assign tx_pkt.prefix = tx_prefix;
    assign tx_pkt.data   = tx_data;

    // Received packet back out to the forwarder
    assign rx_valid  = rx_pkt.valid;
    assign rx_meta   = rx_pkt.meta;
    assign rx_prefix = rx_pkt.prefix;
    assign rx_data   = rx_pkt.data;

    ndn_link_tx #(.PREFIX_BITS(PREFIX_BITS), .DATA_BITS(DATA_BITS)) u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_enable (tx_enable),
        .pkt       (tx_pkt),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .mosi      (mosi)
    );

    ndn_link_rx #(.PREFIX_BITS(PREFIX_BITS), .DATA_BITS(DATA_BITS)) u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx_line (rx_line),
        .pkt     (rx_pkt)
    );

    link_cfg #(.CNT_W(CNT_W)) u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tx_start  (tx_start),
        .rx_mon    (rx_pkt),
        .mosi      (mosi),
        .miso      (miso),
        .tx_enable (tx_enable),
        .rx_line   (rx_line)
    );

endmodule

/* verilog/ndn_link_tx.sv */
// Frame serializer capturing a packet on tx_valid and shifting it out on mosi
module ndn_link_tx #(
    parameter int PREFIX_BITS = ndn_pkg::PREFIX_BITS_DEF,
    parameter int DATA_BITS   = ndn_pkg::DATA_BITS_DEF
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   tx_enable,
    ndn_pkt_if.snk pkt,
    output logic   tx_start,
    output logic   tx_busy,
    output logic   mosi
);

    localparam int META_BITS = ndn_pkg::META_BITS;
    // Bit counter covers the longest field
    localparam int MAX_PD    = (PREFIX_BITS > DATA_BITS) ? PREFIX_BITS : DATA_BITS;
    localparam int MAX_FIELD = (MAX_PD > META_BITS) ? MAX_PD : META_BITS;
    localparam int BIT_W     = $clog2(MAX_FIELD);

    link_pkg::tx_state_e    state;
    logic [BIT_W-1:0]       bit_cnt;
    logic [META_BITS-1:0]   meta_sr;
    logic [PREFIX_BITS-1:0] prefix_sr;
    logic [DATA_BITS-1:0]   data_sr;
    logic                   is_data;
    logic                   accept;
    logic                   field_done;

    // Busy also covers the last bit's cycle, so back-to-back frames get one idle bit
    assign accept     = pkt.valid && tx_enable && !tx_busy;
    assign tx_start   = accept;
    assign field_done = (bit_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= link_pkg::ST_IDLE;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
            mosi    <= link_pkg::LINE_IDLE;
        end else begin
            case (state)
                link_pkg::ST_IDLE: begin
                    if (accept) begin
                        // Start bit goes out right after the capture edge
                        mosi    <= ~link_pkg::LINE_IDLE;
                        state   <= link_pkg::ST_META;
                        bit_cnt <= BIT_W'(META_BITS - 1);
                        tx_busy <= 1'b1;
                    end else begin
                        mosi    <= link_pkg::LINE_IDLE;
                        tx_busy <= 1'b0;
                    end
                end
                link_pkg::ST_META: begin
                    mosi <= meta_sr[META_BITS-1];
                    if (field_done) begin
                        state   <= link_pkg::ST_PREFIX;
                        bit_cnt <= BIT_W'(PREFIX_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                link_pkg::ST_PREFIX: begin
                    mosi <= prefix_sr[PREFIX_BITS-1];
                    if (field_done) begin
                        // Interest frames end after the prefix
                        if (is_data) begin
                            state   <= link_pkg::ST_DATA;
                            bit_cnt <= BIT_W'(DATA_BITS - 1);
                        end else begin
                            state <= link_pkg::ST_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: begin
                    mosi <= data_sr[DATA_BITS-1];
                    if (field_done) begin
                        state <= link_pkg::ST_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Packet copy shifted left so the MSB is always the next bit
    always_ff @(posedge clk) begin
        if (accept) begin
            meta_sr   <= pkt.meta;
            prefix_sr <= pkt.prefix;
            data_sr   <= pkt.data;
            is_data   <= (pkt.meta.kind == ndn_pkg::PKT_DATA);
        end else begin
            case (state)
                link_pkg::ST_META:   meta_sr   <= meta_sr << 1;
                link_pkg::ST_PREFIX: prefix_sr <= prefix_sr << 1;
                link_pkg::ST_DATA:   data_sr   <= data_sr << 1;
                default: ;
            endcase
        end
    end

    // Outside a frame the line sits at its idle level
    a_idle_line: assert property (@(posedge clk) disable iff (rst)
        (state == link_pkg::ST_IDLE) && !tx_busy |-> mosi == link_pkg::LINE_IDLE);

endmodule

/* verilog/ndn_pkg.sv */
// NDN packet format package with the meta byte layout and default field widths
package ndn_pkg;

    // Packet kind as carried in meta bit 6
    typedef enum logic {
        PKT_DATA     = 1'b0,
        PKT_INTEREST = 1'b1
    } pkt_kind_e;

    // Meta byte, first on the wire and MSB first
    // Bit 7 is spare, bit 6 the kind, bits 5..0 the prefix length
    typedef struct packed {
        logic       spare;
        pkt_kind_e  kind;
        // Carried through as received, never checked against PREFIX_BITS
        logic [5:0] prefix_len;
    } ndn_meta_t;

    // Width of the meta field on the line
    localparam int META_BITS = 8;

    // Default prefix name width
    localparam int PREFIX_BITS_DEF = 64;

    // Default content width, only present in data packets
    localparam int DATA_BITS_DEF = 256;

    // Frame length in line cycles = start bit + meta + prefix (+ content)
    // Data frame:     1 + META_BITS + PREFIX_BITS + DATA_BITS
    // Interest frame: 1 + META_BITS + PREFIX_BITS

endpackage

/* verilog/ndn_pkt_if.sv */
// Packet bundle carrying one NDN packet's valid strobe and fields
interface ndn_pkt_if #(
    parameter int PREFIX_BITS = ndn_pkg::PREFIX_BITS_DEF,
    parameter int DATA_BITS   = ndn_pkg::DATA_BITS_DEF
);

    // One-cycle strobe, fields are meaningful while it is high
    logic                   valid;
    ndn_pkg::ndn_meta_t     meta;
    logic [PREFIX_BITS-1:0] prefix;
    // Zero for interest packets on the receive side
    logic [DATA_BITS-1:0]   data;

    // Producer of a packet
    modport src (
        output valid, meta, prefix, data
    );

    // Consumer of a whole packet
    modport snk (
        input valid, meta, prefix, data
    );

    // Observer that only needs the strobe and the kind
    modport mon (
        input valid, meta
    );

endinterface
